//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wall
TOP       ?= tb_mips_decode
FILELIST  ?= verilog.f
PASS_MSG  := Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, fail unless it passes"
	@echo "  clean  remove obj_dir"
	@echo "  help   list the targets"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- decode_inst_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module decode_inst_buffer (
    input  wire logic                           i_clock,
    input  wire logic                           i_reset,
    input  wire logic                           i_fetch_valid,
    input  wire mips_decode_pkg::fetch_bundle_t i_fetch_bundle,
    input  wire logic                           i_pop,      // From output side credit check
    output      mips_decode_pkg::fetch_bundle_t o_head,
    output      logic                           o_not_empty,
    output      logic                           o_fetch_credit
);
    import mips_decode_pkg::*;

    fetch_bundle_t         mem [IN_DEPTH];    // Entry storage
    logic [IN_PTR_W-1:0]   wr_ptr;
    logic [IN_PTR_W-1:0]   rd_ptr;
    logic [IN_CNT_W-1:0]   count;
    logic                  full;

    assign full        = (count == IN_CNT_W'(IN_DEPTH));
    assign o_not_empty = (count != '0);
    assign o_head      = mem[rd_ptr];         // Head seen by decode

    always_ff @(posedge i_clock) begin
        if (i_fetch_valid) begin
            mem[wr_ptr] <= i_fetch_bundle;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            count          <= '0;
            o_fetch_credit <= 1'b0;
        end else begin
            o_fetch_credit <= i_pop;          // One credit back per popped entry
            if (i_fetch_valid) begin
                wr_ptr <= wr_ptr + IN_PTR_W'(1);
            end
            if (i_pop) begin
                rd_ptr <= rd_ptr + IN_PTR_W'(1);
            end
            case ({i_fetch_valid, i_pop})
                2'b10:   count <= count + IN_CNT_W'(1);
                2'b01:   count <= count - IN_CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    // Fetch must never send beyond its credits
    a_no_write_full: assert property (@(posedge i_clock) disable iff (i_reset)
        i_fetch_valid |-> !full);

    // Output side pops only while entries exist
    a_no_pop_empty: assert property (@(posedge i_clock) disable iff (i_reset)
        i_pop |-> o_not_empty);

endmodule

`default_nettype wire

//--- decode_output_reg.sv
`timescale 1ns/10ps
`default_nettype none

module decode_output_reg (
    input  wire logic                           i_clock,
    input  wire logic                           i_reset,
    input  wire logic                           i_not_empty,
    input  wire mips_decode_pkg::id_ex_bundle_t i_bundle,
    input  wire logic                           i_ex_credit,  // Returned by execute
    output      logic                           o_pop,
    output      logic                           o_ex_valid,
    output      mips_decode_pkg::id_ex_bundle_t o_ex_bundle
);
    import mips_decode_pkg::*;

    logic [OUT_CNT_W-1:0] credit_cnt;             // Credits held toward execute

    assign o_pop = i_not_empty && (credit_cnt != '0);

    always_ff @(posedge i_clock) begin
        if (o_pop) begin
            o_ex_bundle <= i_bundle;              // Captured at the pop edge
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            credit_cnt <= OUT_CNT_W'(OUT_CREDITS);
            o_ex_valid <= 1'b0;
        end else begin
            o_ex_valid <= o_pop;
            case ({o_pop, i_ex_credit})
                2'b10:   credit_cnt <= credit_cnt - OUT_CNT_W'(1);
                2'b01:   credit_cnt <= credit_cnt + OUT_CNT_W'(1);
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // Execute returns no more than it was given
    a_credit_bound: assert property (@(posedge i_clock) disable iff (i_reset)
        credit_cnt <= OUT_CNT_W'(OUT_CREDITS));

    // An emitted bundle always holds a credit until execute returns it
    a_valid_spent: assert property (@(posedge i_clock) disable iff (i_reset)
        o_ex_valid |-> (credit_cnt != OUT_CNT_W'(OUT_CREDITS)));

endmodule

`default_nettype wire

//--- mips_control_unit.sv
`timescale 1ns/10ps
`default_nettype none

module mips_control_unit (
    input  wire mips_decode_pkg::opcode_t i_opcode,
    input  wire logic [5:0]               i_funct,
    output      mips_decode_pkg::ctrl_t   o_ctrl
);
    import mips_decode_pkg::*;

    always_comb begin
        o_ctrl        = '0;                       // Everything inactive
        o_ctrl.alu_op = ALU_NOP;
        case (i_opcode)
            OP_RTYPE: begin
                o_ctrl.reg_dest  = 1'b1;
                o_ctrl.reg_write = 1'b1;
                case (i_funct)
                    FN_ADD:  o_ctrl.alu_op = ALU_ADD;
                    FN_SUB:  o_ctrl.alu_op = ALU_SUB;
                    FN_AND:  o_ctrl.alu_op = ALU_AND;
                    FN_OR:   o_ctrl.alu_op = ALU_OR;
                    FN_SLT:  o_ctrl.alu_op = ALU_SLT;
                    FN_SLL:  o_ctrl.alu_op = ALU_SLL;
                    FN_SRL:  o_ctrl.alu_op = ALU_SRL;
                    default: begin
                        o_ctrl         = '0;      // Unknown funct
                        o_ctrl.alu_op  = ALU_NOP;
                        o_ctrl.illegal = 1'b1;
                    end
                endcase
            end
            OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI: begin
                o_ctrl.alu_src      = 1'b1;
                o_ctrl.reg_write    = 1'b1;
                o_ctrl.imm_zero_ext = (i_opcode == OP_ANDI) || (i_opcode == OP_ORI);
                case (i_opcode)
                    OP_SLTI: o_ctrl.alu_op = ALU_SLT;
                    OP_ANDI: o_ctrl.alu_op = ALU_AND;
                    OP_ORI:  o_ctrl.alu_op = ALU_OR;
                    default: o_ctrl.alu_op = ALU_ADD;
                endcase
            end
            OP_LB, OP_LH, OP_LW: begin
                o_ctrl.alu_src     = 1'b1;
                o_ctrl.alu_op      = ALU_ADD;     // Base plus offset
                o_ctrl.mem_read    = 1'b1;
                o_ctrl.mem_to_reg  = 1'b1;
                o_ctrl.reg_write   = 1'b1;
                o_ctrl.byte_en     = (i_opcode == OP_LB);
                o_ctrl.halfword_en = (i_opcode == OP_LH);
                o_ctrl.word_en     = (i_opcode == OP_LW);
            end
            OP_SB, OP_SH, OP_SW: begin
                o_ctrl.alu_src     = 1'b1;
                o_ctrl.alu_op      = ALU_ADD;
                o_ctrl.mem_write   = 1'b1;
                o_ctrl.byte_en     = (i_opcode == OP_SB);
                o_ctrl.halfword_en = (i_opcode == OP_SH);
                o_ctrl.word_en     = (i_opcode == OP_SW);
            end
            OP_BEQ, OP_BNE: begin
                o_ctrl.alu_op    = ALU_SUB;       // Compare by subtraction
                o_ctrl.branch    = 1'b1;
                o_ctrl.branch_ne = (i_opcode == OP_BNE);
            end
            OP_J: begin
                o_ctrl.jump = 1'b1;
            end
            default: begin
                o_ctrl.illegal = 1'b1;            // Unsupported opcode
            end
        endcase
    end

endmodule

`default_nettype wire

//--- mips_decode_pkg.sv
`default_nettype none

package mips_decode_pkg;

    typedef logic [31:0] inst_t;                  // Instruction word
    typedef logic [31:0] word_t;                  // Data or address word
    typedef logic [4:0]  reg_addr_t;              // Register number
    typedef logic [5:0]  opcode_t;                // Opcode field

    localparam int NUM_REGS    = 32;
    localparam int IN_DEPTH    = 4;               // Also fetch's starting credits
    localparam int IN_PTR_W    = $clog2(IN_DEPTH);
    localparam int IN_CNT_W    = $clog2(IN_DEPTH + 1);
    localparam int OUT_CREDITS = 2;
    localparam int OUT_CNT_W   = $clog2(OUT_CREDITS + 1);

    localparam opcode_t OP_RTYPE = 6'd0;
    localparam opcode_t OP_J     = 6'd2;
    localparam opcode_t OP_BEQ   = 6'd4;
    localparam opcode_t OP_BNE   = 6'd5;
    localparam opcode_t OP_ADDI  = 6'd8;
    localparam opcode_t OP_SLTI  = 6'd10;
    localparam opcode_t OP_ANDI  = 6'd12;
    localparam opcode_t OP_ORI   = 6'd13;
    localparam opcode_t OP_LB    = 6'd32;
    localparam opcode_t OP_LH    = 6'd33;
    localparam opcode_t OP_LW    = 6'd35;
    localparam opcode_t OP_SB    = 6'd40;
    localparam opcode_t OP_SH    = 6'd41;
    localparam opcode_t OP_SW    = 6'd43;

    localparam logic [5:0] FN_SLL = 6'h00;
    localparam logic [5:0] FN_SRL = 6'h02;
    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_SLT = 4'd4,
        ALU_SLL = 4'd5,
        ALU_SRL = 4'd6,
        ALU_NOP = 4'd7
    } alu_op_t;

    typedef struct packed {
        inst_t inst;
        word_t pc_plus4;
    } fetch_bundle_t;

    typedef struct packed {
        logic      write_en;
        reg_addr_t write_reg;
        word_t     write_data;
    } wb_write_t;

    typedef struct packed {
        logic    reg_dest;                        // EX
        logic    alu_src;                         // EX
        alu_op_t alu_op;                          // EX
        logic    mem_read;                        // MEM
        logic    mem_write;                       // MEM
        logic    branch;                          // MEM
        logic    branch_ne;                       // MEM, bne variant
        logic    reg_write;                       // WB
        logic    mem_to_reg;                      // WB
        logic    jump;
        logic    byte_en;
        logic    halfword_en;
        logic    word_en;
        logic    imm_zero_ext;
        logic    illegal;
    } ctrl_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     data_a;
        word_t     data_b;
        word_t     immediate;
        word_t     shamt;
        reg_addr_t rt;
        reg_addr_t rd;
        word_t     jump_address;
        word_t     pc_plus4;
    } id_ex_bundle_t;

endpackage

`default_nettype wire

//--- mips_decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module mips_decode_stage (
    input  wire logic                           i_clock,
    input  wire logic                           i_reset,
    input  wire mips_decode_pkg::fetch_bundle_t i_fetch,
    input  wire mips_decode_pkg::wb_write_t     i_wb,
    output      mips_decode_pkg::id_ex_bundle_t o_bundle
);
    import mips_decode_pkg::*;

    opcode_t     opcode;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic [4:0]  shamt;
    logic [5:0]  funct;
    logic [15:0] imm;
    logic [25:0] target;
    word_t       data_a;
    word_t       data_b;
    ctrl_t       dec_ctrl;

    assign opcode = i_fetch.inst[31:26];
    assign rs     = i_fetch.inst[25:21];
    assign rt     = i_fetch.inst[20:16];
    assign rd     = i_fetch.inst[15:11];
    assign shamt  = i_fetch.inst[10:6];
    assign funct  = i_fetch.inst[5:0];
    assign imm    = i_fetch.inst[15:0];
    assign target = i_fetch.inst[25:0];

    mips_register_file u_register_file (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_read_reg_a (rs),
        .i_read_reg_b (rt),
        .i_wb         (i_wb),
        .o_data_a     (data_a),
        .o_data_b     (data_b)
    );

    mips_control_unit u_control_unit (
        .i_opcode (opcode),
        .i_funct  (funct),
        .o_ctrl   (dec_ctrl)
    );

    always_comb begin
        o_bundle.ctrl         = dec_ctrl;
        o_bundle.data_a       = data_a;
        o_bundle.data_b       = data_b;
        o_bundle.immediate    = dec_ctrl.imm_zero_ext ? {16'b0, imm}    // andi, ori
                                                      : {{16{imm[15]}}, imm};
        o_bundle.shamt        = {27'b0, shamt};
        o_bundle.rt           = rt;
        o_bundle.rd           = rd;
        o_bundle.jump_address = {i_fetch.pc_plus4[31:28], target, 2'b00};  // Same 256 MB region
        o_bundle.pc_plus4     = i_fetch.pc_plus4;
    end

endmodule

`default_nettype wire

//--- mips_decode_top.sv
`timescale 1ns/10ps
`default_nettype none

module mips_decode_top (
    input  wire logic                           i_clock,
    input  wire logic                           i_reset,
    input  wire logic                           i_fetch_valid,
    input  wire mips_decode_pkg::fetch_bundle_t i_fetch_bundle,
    input  wire mips_decode_pkg::wb_write_t     i_wb,
    input  wire logic                           i_ex_credit,
    output      logic                           o_fetch_credit,
    output      logic                           o_ex_valid,
    output      mips_decode_pkg::id_ex_bundle_t o_ex_bundle
);
    import mips_decode_pkg::*;

    fetch_bundle_t head;                          // Buffer head into decode
    id_ex_bundle_t dec_bundle;
    logic          not_empty;
    logic          pop;

    decode_inst_buffer u_inst_buffer (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_fetch_valid  (i_fetch_valid),
        .i_fetch_bundle (i_fetch_bundle),
        .i_pop          (pop),
        .o_head         (head),
        .o_not_empty    (not_empty),
        .o_fetch_credit (o_fetch_credit)
    );

    mips_decode_stage u_decode_stage (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_fetch  (head),
        .i_wb     (i_wb),
        .o_bundle (dec_bundle)
    );

    decode_output_reg u_output_reg (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_not_empty (not_empty),
        .i_bundle    (dec_bundle),
        .i_ex_credit (i_ex_credit),
        .o_pop       (pop),
        .o_ex_valid  (o_ex_valid),
        .o_ex_bundle (o_ex_bundle)
    );

endmodule

`default_nettype wire

//--- mips_register_file.sv
`timescale 1ns/10ps
`default_nettype none

module mips_register_file (
    input  wire logic                       i_clock,
    input  wire logic                       i_reset,
    input  wire mips_decode_pkg::reg_addr_t i_read_reg_a,
    input  wire mips_decode_pkg::reg_addr_t i_read_reg_b,
    input  wire mips_decode_pkg::wb_write_t i_wb,
    output      mips_decode_pkg::word_t     o_data_a,
    output      mips_decode_pkg::word_t     o_data_b
);
    import mips_decode_pkg::*;

    word_t regs [NUM_REGS];
    logic  wb_active;                             // Write that actually lands

    assign wb_active = i_wb.write_en && (i_wb.write_reg != '0);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_active) begin
            regs[i_wb.write_reg] <= i_wb.write_data;  // $zero never written
        end
    end

    // Same-cycle write is bypassed to the reads
    always_comb begin
        if (wb_active && (i_wb.write_reg == i_read_reg_a)) begin
            o_data_a = i_wb.write_data;
        end else begin
            o_data_a = regs[i_read_reg_a];
        end
        if (wb_active && (i_wb.write_reg == i_read_reg_b)) begin
            o_data_b = i_wb.write_data;
        end else begin
            o_data_b = regs[i_read_reg_b];
        end
    end

endmodule

`default_nettype wire

//--- tb_decode_checker.sv
`timescale 1ns/10ps
`default_nettype none

module tb_decode_checker (
    input  wire logic                           i_clock,
    input  wire logic                           i_reset,
    input  wire logic                           i_fetch_valid,
    input  wire mips_decode_pkg::fetch_bundle_t i_fetch_bundle,
    input  wire mips_decode_pkg::wb_write_t     i_wb,
    input  wire logic                           i_ex_credit,
    input  wire logic                           i_ex_valid,
    input  wire mips_decode_pkg::id_ex_bundle_t i_ex_bundle,
    input  wire logic                           i_fetch_credit,
    input  string                               i_test_name,
    output int                                  o_error_count,
    output int                                  o_popped,
    output int                                  o_pending
);
    import mips_decode_pkg::*;

    word_t         model_regs [NUM_REGS];
    word_t         snap_regs [NUM_REGS];     // Register view at the last edge
    fetch_bundle_t pending_q [$];
    logic          seen_fetch;
    int            in_flight;                 // Emitted bundles not yet credited

    function automatic ctrl_t model_ctrl(inst_t inst);
        ctrl_t      c;
        opcode_t    op;
        logic [5:0] fn;
        op = inst[31:26];
        fn = inst[5:0];
        c = '0;
        c.alu_op = ALU_NOP;
        if (op == OP_RTYPE) begin
            c.reg_dest = 1'b1;
            c.reg_write = 1'b1;
            if (fn == FN_ADD) c.alu_op = ALU_ADD;
            else if (fn == FN_SUB) c.alu_op = ALU_SUB;
            else if (fn == FN_AND) c.alu_op = ALU_AND;
            else if (fn == FN_OR) c.alu_op = ALU_OR;
            else if (fn == FN_SLT) c.alu_op = ALU_SLT;
            else if (fn == FN_SLL) c.alu_op = ALU_SLL;
            else if (fn == FN_SRL) c.alu_op = ALU_SRL;
            else begin
                c = '0;
                c.alu_op = ALU_NOP;
                c.illegal = 1'b1;
            end
        end else if (op == OP_ADDI || op == OP_SLTI || op == OP_ANDI || op == OP_ORI) begin
            c.alu_src = 1'b1;
            c.reg_write = 1'b1;
            c.imm_zero_ext = (op == OP_ANDI) || (op == OP_ORI);
            c.alu_op = (op == OP_ADDI) ? ALU_ADD : (op == OP_SLTI) ? ALU_SLT
                     : (op == OP_ANDI) ? ALU_AND : ALU_OR;
        end else if (op == OP_LB || op == OP_LH || op == OP_LW) begin
            c.alu_src = 1'b1;
            c.alu_op = ALU_ADD;
            c.mem_read = 1'b1;
            c.mem_to_reg = 1'b1;
            c.reg_write = 1'b1;
            c.byte_en = (op == OP_LB);
            c.halfword_en = (op == OP_LH);
            c.word_en = (op == OP_LW);
        end else if (op == OP_SB || op == OP_SH || op == OP_SW) begin
            c.alu_src = 1'b1;
            c.alu_op = ALU_ADD;
            c.mem_write = 1'b1;
            c.byte_en = (op == OP_SB);
            c.halfword_en = (op == OP_SH);
            c.word_en = (op == OP_SW);
        end else if (op == OP_BEQ || op == OP_BNE) begin
            c.alu_op = ALU_SUB;
            c.branch = 1'b1;
            c.branch_ne = (op == OP_BNE);
        end else if (op == OP_J) begin
            c.jump = 1'b1;
        end else begin
            c.illegal = 1'b1;
        end
        return c;
    endfunction

    task automatic check_field(input string field, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            o_error_count++;
            $display("mismatch %s %s: expected %h actual %h", i_test_name, field, exp, act);
        end
    endtask

    task automatic compare_bundle(input fetch_bundle_t fb);
        ctrl_t       c;
        logic [15:0] imm;
        c = model_ctrl(fb.inst);
        imm = fb.inst[15:0];
        check_field("ctrl", 32'(c), 32'(i_ex_bundle.ctrl));
        check_field("data_a", snap_regs[fb.inst[25:21]], i_ex_bundle.data_a);
        check_field("data_b", snap_regs[fb.inst[20:16]], i_ex_bundle.data_b);
        check_field("immediate", c.imm_zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm},
                    i_ex_bundle.immediate);
        check_field("shamt", {27'd0, fb.inst[10:6]}, i_ex_bundle.shamt);
        check_field("rt", {27'd0, fb.inst[20:16]}, 32'(i_ex_bundle.rt));
        check_field("rd", {27'd0, fb.inst[15:11]}, 32'(i_ex_bundle.rd));
        check_field("jump_address", {fb.pc_plus4[31:28], fb.inst[25:0], 2'b00},
                    i_ex_bundle.jump_address);
        check_field("pc_plus4", fb.pc_plus4, i_ex_bundle.pc_plus4);
    endtask

    task automatic step();
        fetch_bundle_t fb;
        if (i_reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                model_regs[i] = '0;
                snap_regs[i] = '0;
            end
            pending_q.delete();
            seen_fetch = 1'b0;
            in_flight = 0;
        end else begin
            if (!seen_fetch && (i_ex_valid || i_fetch_credit)) begin
                o_error_count++;
                $display("%s: output active before any instruction was sent", i_test_name);
            end
            if (i_ex_valid) begin
                in_flight++;
                if (pending_q.size() == 0) begin
                    o_error_count++;
                    $display("%s: bundle emitted with no instruction pending", i_test_name);
                end else begin
                    fb = pending_q.pop_front();
                    o_popped++;
                    compare_bundle(fb);
                end
            end
            if (i_ex_credit) in_flight--;
            if (in_flight > OUT_CREDITS) begin
                o_error_count++;
                $display("%s: more bundles in flight than execute credits", i_test_name);
            end
            if (i_wb.write_en && i_wb.write_reg != 5'd0) begin
                model_regs[i_wb.write_reg] = i_wb.write_data;
            end
            snap_regs = model_regs;          // What a pop at this edge reads
            if (i_fetch_valid) begin
                pending_q.push_back(i_fetch_bundle);
                seen_fetch = 1'b1;
            end
        end
        o_pending = pending_q.size();
    endtask

    initial begin
        o_error_count = 0;
        o_popped = 0;
        o_pending = 0;
        forever begin
            @(posedge i_clock);
            step();
        end
    end

endmodule

`default_nettype wire

//--- tb_mips_decode.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mips_decode;
    import mips_decode_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int N_REGFILE   = 40;
    localparam int N_DECODE    = 200;
    localparam int N_ILLEGAL   = 40;
    localparam int N_BACKP     = 80;
    localparam int TOTAL_INSTS = N_REGFILE + N_DECODE + N_ILLEGAL + N_BACKP;
    localparam int DRAIN_LIMIT = 100;         // Cycles allowed to empty the pipe

    logic          clock;
    logic          reset;
    logic          fetch_valid;
    fetch_bundle_t fetch_bundle;
    wb_write_t     wb;
    logic          ex_credit;
    logic          fetch_credit;
    logic          ex_valid;
    id_ex_bundle_t ex_bundle;
    string         test_name;
    int            checker_errors;
    int            popped;
    int            pending;
    int            tb_errors;
    int            last_errors;
    int            fetch_credits;             // Credits held by the fetch side
    int            ex_outstanding;            // Emitted bundles awaiting a credit
    int            total_sent;
    int            send_pct;
    int            credit_pct;
    int            wb_pct;
    logic [4:0]    wb_mask;

    mips_decode_top dut (
        .i_clock        (clock),
        .i_reset        (reset),
        .i_fetch_valid  (fetch_valid),
        .i_fetch_bundle (fetch_bundle),
        .i_wb           (wb),
        .i_ex_credit    (ex_credit),
        .o_fetch_credit (fetch_credit),
        .o_ex_valid     (ex_valid),
        .o_ex_bundle    (ex_bundle)
    );

    tb_decode_checker u_checker (
        .i_clock        (clock),
        .i_reset        (reset),
        .i_fetch_valid  (fetch_valid),
        .i_fetch_bundle (fetch_bundle),
        .i_wb           (wb),
        .i_ex_credit    (ex_credit),
        .i_ex_valid     (ex_valid),
        .i_ex_bundle    (ex_bundle),
        .i_fetch_credit (fetch_credit),
        .i_test_name    (test_name),
        .o_error_count  (checker_errors),
        .o_popped       (popped),
        .o_pending      (pending)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    function automatic opcode_t op_at(int idx);
        case (idx)
            0: return OP_RTYPE;
            1: return OP_J;
            2: return OP_BEQ;
            3: return OP_BNE;
            4: return OP_ADDI;
            5: return OP_SLTI;
            6: return OP_ANDI;
            7: return OP_ORI;
            8: return OP_LB;
            9: return OP_LH;
            10: return OP_LW;
            11: return OP_SB;
            12: return OP_SH;
            default: return OP_SW;
        endcase
    endfunction

    function automatic logic [5:0] funct_at(int idx);
        case (idx)
            0: return FN_ADD;
            1: return FN_SUB;
            2: return FN_AND;
            3: return FN_OR;
            4: return FN_SLT;
            5: return FN_SLL;
            default: return FN_SRL;
        endcase
    endfunction

    function automatic logic op_known(opcode_t op);
        for (int i = 0; i < 14; i++) begin
            if (op_at(i) == op) return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic logic funct_known(logic [5:0] fn);
        for (int i = 0; i < 7; i++) begin
            if (funct_at(i) == fn) return 1'b1;
        end
        return 1'b0;
    endfunction

    // Kind 1 is add over r0..r3, 2 is any opcode, 3 is illegal only
    function automatic inst_t gen_inst(int kind);
        logic [31:0] r;
        logic [31:0] f;
        opcode_t     op;
        logic [5:0]  fn;
        r = $urandom;
        f = $urandom;
        if (kind == 1) begin
            return {OP_RTYPE, 3'b000, r[1:0], 3'b000, r[3:2], r[8:4], 5'd0, FN_ADD};
        end
        if (kind == 3 || r[31:28] == 4'hf) begin
            if (r[27]) begin
                fn = r[5:0];
                while (funct_known(fn)) fn = fn + 6'd1;
                return {OP_RTYPE, f[25:6], fn};
            end
            op = r[5:0];
            while (op_known(op)) op = op + 6'd1;
            return {op, f[25:0]};
        end
        op = op_at(int'(r % 32'd14));
        fn = funct_at(int'(f % 32'd7));
        if (op == OP_RTYPE) return {op, f[25:6], fn};
        return {op, f[25:0]};
    endfunction

    task automatic drive_cycle(input bit want_send, input int kind);
        logic [31:0] r;
        @(negedge clock);
        if (fetch_credit) fetch_credits++;
        if (ex_valid) ex_outstanding++;
        fetch_valid = 1'b0;
        wb = '0;
        ex_credit = 1'b0;
        r = $urandom;
        if (want_send && fetch_credits > 0 && int'(r % 32'd100) < send_pct) begin
            fetch_bundle.inst = gen_inst(kind);
            fetch_bundle.pc_plus4 = {r[31:2], 2'b00};
            fetch_valid = 1'b1;
            fetch_credits--;
            total_sent++;
        end
        r = $urandom;
        if (int'(r % 32'd100) < wb_pct) begin
            wb.write_en = 1'b1;
            wb.write_reg = r[31:27] & wb_mask;
            wb.write_data = $urandom;
        end
        r = $urandom;
        if (ex_outstanding > 0 && int'(r % 32'd100) < credit_pct) begin
            ex_credit = 1'b1;
            ex_outstanding--;
        end
    endtask

    task automatic report_test();
        $display("test %s done: %0d errors", test_name,
                 checker_errors + tb_errors - last_errors);
        last_errors = checker_errors + tb_errors;
    endtask

    task automatic run_test(input string name, input int n, input int kind, input int sp,
                            input int cp, input int wp, input logic [4:0] mask);
        int sent;
        int drain;
        test_name = name;
        send_pct = sp;
        credit_pct = cp;
        wb_pct = wp;
        wb_mask = mask;
        sent = 0;
        drain = 0;
        while (sent < n) begin
            drive_cycle(1'b1, kind);
            if (fetch_valid) sent++;
        end
        while ((pending != 0 || fetch_credits != IN_DEPTH) && drain < DRAIN_LIMIT) begin
            drive_cycle(1'b0, kind);
            drain++;
        end
        if (pending != 0 || fetch_credits != IN_DEPTH) begin
            tb_errors++;
            $display("%s: DUT did not drain within %0d cycles", name, DRAIN_LIMIT);
        end
        report_test();
    endtask

    // Generous bound of 20 cycles per instruction
    initial begin
        #(TOTAL_INSTS * 20 * CLK_PERIOD);
        $display("Watchdog expired before the tests completed");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        void'($urandom(32'hc3a6_ec6e));
        clock = 1'b0;
        reset = 1'b1;
        fetch_valid = 1'b0;
        fetch_bundle = '0;
        wb = '0;
        ex_credit = 1'b0;
        test_name = "reset";
        tb_errors = 0;
        last_errors = 0;
        fetch_credits = IN_DEPTH;
        ex_outstanding = 0;
        total_sent = 0;
        send_pct = 0;
        credit_pct = 50;
        wb_pct = 0;
        wb_mask = 5'h1f;
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        repeat (6) drive_cycle(1'b0, 0);      // Outputs must stay idle
        report_test();

        run_test("regfile", N_REGFILE, 1, 60, 70, 60, 5'h03);
        run_test("decode", N_DECODE, 2, 70, 70, 30, 5'h1f);
        run_test("illegal", N_ILLEGAL, 3, 70, 70, 20, 5'h1f);
        run_test("backpressure", N_BACKP, 2, 90, 20, 30, 5'h1f);

        test_name = "credits";
        if (fetch_credits != IN_DEPTH) begin
            tb_errors++;
            $display("fetch holds %0d credits instead of %0d", fetch_credits, IN_DEPTH);
        end
        if (popped != total_sent) begin
            tb_errors++;
            $display("%0d bundles emitted for %0d instructions sent", popped, total_sent);
        end
        report_test();

        $display("6 tests, %0d bundles checked, %0d errors", popped, checker_errors + tb_errors);
        if (checker_errors + tb_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
mips_decode_pkg.sv
decode_inst_buffer.sv
mips_register_file.sv
mips_control_unit.sv
mips_decode_stage.sv
decode_output_reg.sv
mips_decode_top.sv
tb_decode_checker.sv
tb_mips_decode.sv
